/* verilog/wisc_pkg.sv */
package wisc_pkg;

    localparam int DATA_W    = 16;
    localparam int REG_CNT   = 8;
    localparam int REG_IDX_W = $clog2(REG_CNT);
    localparam logic [REG_IDX_W-1:0] LINK_REG = 3'd7;  // JAL and JALR link target

    typedef enum logic [4:0] {
        OP_HALT  = 5'b00000,
        OP_NOP   = 5'b00001,
        OP_J     = 5'b00100,
        OP_JR    = 5'b00101,
        OP_JAL   = 5'b00110,
        OP_JALR  = 5'b00111,
        OP_ADDI  = 5'b01000,
        OP_SUBI  = 5'b01001,
        OP_XORI  = 5'b01010,
        OP_ANDNI = 5'b01011,
        OP_BEQZ  = 5'b01100,
        OP_BNEZ  = 5'b01101,
        OP_BLTZ  = 5'b01110,
        OP_BGEZ  = 5'b01111,
        OP_ST    = 5'b10000,
        OP_LD    = 5'b10001,
        OP_SLBI  = 5'b10010,
        OP_STU   = 5'b10011,
        OP_ROLI  = 5'b10100,
        OP_SLLI  = 5'b10101,
        OP_RORI  = 5'b10110,
        OP_SRLI  = 5'b10111,
        OP_LBI   = 5'b11000,
        OP_BTR   = 5'b11001,
        OP_SHIFT = 5'b11010,  // ROL, SLL, ROR, SRL by function
        OP_ARITH = 5'b11011,  // ADD, SUB, XOR, ANDN by function
        OP_SEQ   = 5'b11100,
        OP_SLT   = 5'b11101,
        OP_SLE   = 5'b11110,
        OP_SCO   = 5'b11111
    } opcode_e;

    typedef enum logic [2:0] {
        SRC_REG   = 3'd0,
        SRC_SIMM5 = 3'd1,
        SRC_ZIMM5 = 3'd2,
        SRC_SIMM8 = 3'd3,
        SRC_ZIMM8 = 3'd4,
        SRC_ZERO  = 3'd5,
        SRC_NONE  = 3'd7
    } alu_src_e;

    typedef enum logic [1:0] {
        DST_4_2  = 2'd0,
        DST_7_5  = 2'd1,
        DST_10_8 = 2'd2,
        DST_R7   = 2'd3
    } reg_dst_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_XOR, ALU_ANDN,
        ALU_ROL, ALU_SLL, ALU_ROR, ALU_SRL,
        ALU_SEQ, ALU_SLT, ALU_SLE, ALU_SCO,
        ALU_BTR, ALU_PASSB, ALU_SLBI
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQZ, BR_NEZ, BR_LTZ, BR_GEZ, BR_J, BR_JR
    } br_cond_e;

endpackage

/* verilog/master_ctrl.sv */
module master_ctrl (
    input  wisc_pkg::opcode_e  opcode,
    input  logic [1:0]         lower_two,
    output wisc_pkg::alu_src_e alu_src,
    output logic               mem_write,
    output logic               mem_read,
    output logic               reg_write,
    output logic               mem_to_reg,
    output wisc_pkg::reg_dst_e reg_dst,
    output logic               invA,
    output logic               invB,
    output logic               Cin,
    output wisc_pkg::alu_op_e  alu_op,
    output wisc_pkg::br_cond_e br_cond,
    output logic               dump
);

    always_comb begin
        alu_src    = wisc_pkg::SRC_NONE;
        mem_write  = 1'b0;
        mem_read   = 1'b0;
        reg_write  = 1'b0;
        mem_to_reg = 1'b0;
        reg_dst    = wisc_pkg::DST_7_5;
        invA       = 1'b0;
        invB       = 1'b0;
        Cin        = 1'b0;
        alu_op     = wisc_pkg::ALU_ADD;
        br_cond    = wisc_pkg::BR_NONE;
        dump       = 1'b0;

        case (opcode)
            wisc_pkg::OP_HALT: dump = 1'b1;
            wisc_pkg::OP_ADDI, wisc_pkg::OP_SUBI: begin
                alu_src   = wisc_pkg::SRC_SIMM5;
                reg_write = 1'b1;
                invA      = (opcode == wisc_pkg::OP_SUBI);  // imm - Rs
                Cin       = (opcode == wisc_pkg::OP_SUBI);
            end
            wisc_pkg::OP_XORI, wisc_pkg::OP_ANDNI: begin
                alu_src   = wisc_pkg::SRC_ZIMM5;
                reg_write = 1'b1;
                invB      = (opcode == wisc_pkg::OP_ANDNI);
                alu_op    = (opcode == wisc_pkg::OP_XORI) ? wisc_pkg::ALU_XOR
                                                          : wisc_pkg::ALU_ANDN;
            end
            wisc_pkg::OP_ROLI, wisc_pkg::OP_SLLI, wisc_pkg::OP_RORI, wisc_pkg::OP_SRLI: begin
                alu_src   = wisc_pkg::SRC_ZIMM5;
                reg_write = 1'b1;
                alu_op    = wisc_pkg::alu_op_e'(wisc_pkg::ALU_ROL + opcode[1:0]);
            end
            wisc_pkg::OP_ST, wisc_pkg::OP_STU: begin
                alu_src   = wisc_pkg::SRC_SIMM5;
                mem_write = 1'b1;
                reg_write = (opcode == wisc_pkg::OP_STU);  // Base update to Rs
                reg_dst   = wisc_pkg::DST_10_8;
            end
            wisc_pkg::OP_LD: begin
                alu_src    = wisc_pkg::SRC_SIMM5;
                mem_read   = 1'b1;
                reg_write  = 1'b1;
                mem_to_reg = 1'b1;
            end
            wisc_pkg::OP_BTR: begin
                reg_write = 1'b1;
                reg_dst   = wisc_pkg::DST_4_2;
                alu_op    = wisc_pkg::ALU_BTR;
            end
            wisc_pkg::OP_ARITH: begin
                alu_src   = wisc_pkg::SRC_REG;
                reg_write = 1'b1;
                reg_dst   = wisc_pkg::DST_4_2;
                invA      = (lower_two == 2'b01);  // SUB is Rt - Rs
                Cin       = (lower_two == 2'b01);
                invB      = (lower_two == 2'b11);
                case (lower_two)
                    2'b10:   alu_op = wisc_pkg::ALU_XOR;
                    2'b11:   alu_op = wisc_pkg::ALU_ANDN;
                    default: alu_op = wisc_pkg::ALU_ADD;
                endcase
            end
            wisc_pkg::OP_SHIFT: begin
                alu_src   = wisc_pkg::SRC_REG;
                reg_write = 1'b1;
                reg_dst   = wisc_pkg::DST_4_2;
                alu_op    = wisc_pkg::alu_op_e'(wisc_pkg::ALU_ROL + lower_two);
            end
            wisc_pkg::OP_SEQ, wisc_pkg::OP_SLT, wisc_pkg::OP_SLE, wisc_pkg::OP_SCO: begin
                alu_src   = wisc_pkg::SRC_REG;
                reg_write = 1'b1;
                reg_dst   = wisc_pkg::DST_4_2;
                invB      = (opcode != wisc_pkg::OP_SCO);
                Cin       = (opcode != wisc_pkg::OP_SCO);
                alu_op    = wisc_pkg::alu_op_e'(wisc_pkg::ALU_SEQ + opcode[1:0]);
            end
            wisc_pkg::OP_BEQZ, wisc_pkg::OP_BNEZ, wisc_pkg::OP_BLTZ, wisc_pkg::OP_BGEZ: begin
                alu_src = wisc_pkg::SRC_ZERO;
                invB    = 1'b1;
                Cin     = 1'b1;
                br_cond = wisc_pkg::br_cond_e'(wisc_pkg::BR_EQZ + opcode[1:0]);
            end
            wisc_pkg::OP_LBI, wisc_pkg::OP_SLBI: begin
                reg_write = 1'b1;
                reg_dst   = wisc_pkg::DST_10_8;
                if (opcode == wisc_pkg::OP_LBI) begin
                    alu_src = wisc_pkg::SRC_SIMM8;
                    alu_op  = wisc_pkg::ALU_PASSB;
                end else begin
                    alu_src = wisc_pkg::SRC_ZIMM8;
                    alu_op  = wisc_pkg::ALU_SLBI;
                end
            end
            wisc_pkg::OP_J, wisc_pkg::OP_JAL, wisc_pkg::OP_JR, wisc_pkg::OP_JALR: begin
                reg_write = opcode[1];  // JAL and JALR link
                reg_dst   = wisc_pkg::DST_R7;
                br_cond   = opcode[0] ? wisc_pkg::BR_JR : wisc_pkg::BR_J;
            end
            default: ;  // NOP and unknown opcodes
        endcase
    end

    // Load writeback and store are exclusive for every opcode
    always_comb begin
        assert final (!(mem_write && mem_to_reg))
            else $error("master_ctrl: mem_write and mem_to_reg both set, opcode %h", opcode);
    end

endmodule

/* verilog/reg_file.sv */
module reg_file (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [wisc_pkg::REG_IDX_W-1:0]    rd_a_idx,
    input  logic [wisc_pkg::REG_IDX_W-1:0]    rd_b_idx,
    output logic [wisc_pkg::DATA_W-1:0]       rd_a,
    output logic [wisc_pkg::DATA_W-1:0]       rd_b,
    input  logic                              wr_en,
    input  logic [wisc_pkg::REG_IDX_W-1:0]    wr_idx,
    input  logic [wisc_pkg::DATA_W-1:0]       wr_data
);

    logic [wisc_pkg::DATA_W-1:0] regs [wisc_pkg::REG_CNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < wisc_pkg::REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rd_a = regs[rd_a_idx];  // No write bypass, single cycle core
    assign rd_b = regs[rd_b_idx];

    // Writeback source must be resolved, including load data from outside
    assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> !$isunknown(wr_data))
        else $error("reg_file: unknown wr_data %h to R%0d", wr_data, wr_idx);

endmodule

/* verilog/alu.sv */
module alu (
    input  logic [wisc_pkg::DATA_W-1:0] a,
    input  logic [wisc_pkg::DATA_W-1:0] b,
    input  logic                        invA,
    input  logic                        invB,
    input  logic                        Cin,
    input  wisc_pkg::alu_op_e           alu_op,
    output logic [wisc_pkg::DATA_W-1:0] result
);

    logic [wisc_pkg::DATA_W-1:0]   a_eff;
    logic [wisc_pkg::DATA_W-1:0]   b_eff;
    logic [wisc_pkg::DATA_W-1:0]   sum;
    logic [wisc_pkg::DATA_W-1:0]   rev;
    logic [2*wisc_pkg::DATA_W-1:0] rot_l;
    logic [2*wisc_pkg::DATA_W-1:0] rot_r;
    logic [wisc_pkg::DATA_W:0]     diff;
    logic [wisc_pkg::DATA_W:0]     carry_sum;
    logic [3:0]                    shamt;

    assign a_eff = invA ? ~a : a;
    assign b_eff = invB ? ~b : b;
    assign sum   = a_eff + b_eff + {{(wisc_pkg::DATA_W-1){1'b0}}, Cin};

    assign shamt = b[3:0];
    assign rot_l = {a, a} << shamt;
    assign rot_r = {a, a} >> shamt;

    // B - A with one guard bit, sign is exact for signed inputs
    assign diff      = {b[wisc_pkg::DATA_W-1], b} - {a[wisc_pkg::DATA_W-1], a};
    assign carry_sum = {1'b0, a} + {1'b0, b};

    always_comb begin
        for (int i = 0; i < wisc_pkg::DATA_W; i++) begin
            rev[i] = a[wisc_pkg::DATA_W-1-i];
        end
    end

    always_comb begin
        result = '0;
        case (alu_op)
            wisc_pkg::ALU_ADD:   result = sum;
            wisc_pkg::ALU_XOR:   result = a_eff ^ b_eff;
            wisc_pkg::ALU_ANDN:  result = a_eff & b_eff;  // B already inverted
            wisc_pkg::ALU_ROL:   result = rot_l[2*wisc_pkg::DATA_W-1:wisc_pkg::DATA_W];
            wisc_pkg::ALU_SLL:   result = a << shamt;
            wisc_pkg::ALU_ROR:   result = rot_r[wisc_pkg::DATA_W-1:0];
            wisc_pkg::ALU_SRL:   result = a >> shamt;
            wisc_pkg::ALU_SEQ:   result[0] = (diff == '0);
            wisc_pkg::ALU_SLT:   result[0] = !diff[wisc_pkg::DATA_W] && (diff != '0);
            wisc_pkg::ALU_SLE:   result[0] = !diff[wisc_pkg::DATA_W];
            wisc_pkg::ALU_SCO:   result[0] = carry_sum[wisc_pkg::DATA_W];
            wisc_pkg::ALU_BTR:   result = rev;
            wisc_pkg::ALU_PASSB: result = b;
            wisc_pkg::ALU_SLBI:  result = (a << 8) | b;
            default:             result = sum;
        endcase
    end

endmodule

/* verilog/operand_sel.sv */
module operand_sel (
    input  logic [wisc_pkg::DATA_W-1:0]    instr,
    input  wisc_pkg::alu_src_e             alu_src,
    input  wisc_pkg::reg_dst_e             reg_dst,
    input  logic [wisc_pkg::DATA_W-1:0]    rt_data,
    output logic [wisc_pkg::DATA_W-1:0]    op_b,
    output logic [wisc_pkg::REG_IDX_W-1:0] wr_idx
);

    logic [wisc_pkg::DATA_W-1:0] simm5;
    logic [wisc_pkg::DATA_W-1:0] zimm5;
    logic [wisc_pkg::DATA_W-1:0] simm8;
    logic [wisc_pkg::DATA_W-1:0] zimm8;

    assign simm5 = {{(wisc_pkg::DATA_W-5){instr[4]}}, instr[4:0]};
    assign zimm5 = {{(wisc_pkg::DATA_W-5){1'b0}}, instr[4:0]};
    assign simm8 = {{(wisc_pkg::DATA_W-8){instr[7]}}, instr[7:0]};
    assign zimm8 = {{(wisc_pkg::DATA_W-8){1'b0}}, instr[7:0]};

    always_comb begin
        case (alu_src)
            wisc_pkg::SRC_REG:   op_b = rt_data;
            wisc_pkg::SRC_SIMM5: op_b = simm5;
            wisc_pkg::SRC_ZIMM5: op_b = zimm5;
            wisc_pkg::SRC_SIMM8: op_b = simm8;
            wisc_pkg::SRC_ZIMM8: op_b = zimm8;
            default:             op_b = '0;  // Zero and don't care
        endcase
    end

    always_comb begin
        case (reg_dst)
            wisc_pkg::DST_4_2:  wr_idx = instr[4:2];
            wisc_pkg::DST_7_5:  wr_idx = instr[7:5];
            wisc_pkg::DST_10_8: wr_idx = instr[10:8];
            default:            wr_idx = wisc_pkg::LINK_REG;
        endcase
    end

endmodule

/* verilog/pc_unit.sv */
module pc_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [wisc_pkg::DATA_W-1:0] instr,
    input  wisc_pkg::br_cond_e          br_cond,
    input  logic [wisc_pkg::DATA_W-1:0] rs_data,
    input  logic                        dump,
    output logic [wisc_pkg::DATA_W-1:0] pc,
    output logic [wisc_pkg::DATA_W-1:0] pc_inc,
    output logic                        halt
);

    logic [wisc_pkg::DATA_W-1:0] imm8_sext;
    logic [wisc_pkg::DATA_W-1:0] disp_sext;
    logic [wisc_pkg::DATA_W-1:0] pc_next;
    logic                        rs_zero;
    logic                        rs_neg;
    logic                        halt_q;

    assign imm8_sext = {{(wisc_pkg::DATA_W-8){instr[7]}}, instr[7:0]};
    assign disp_sext = {{(wisc_pkg::DATA_W-11){instr[10]}}, instr[10:0]};
    assign pc_inc    = pc + 16'd2;
    assign rs_zero   = (rs_data == '0);
    assign rs_neg    = rs_data[wisc_pkg::DATA_W-1];
    assign halt      = dump | halt_q;  // High in the HALT cycle itself

    always_comb begin
        case (br_cond)
            wisc_pkg::BR_EQZ: pc_next = rs_zero ? pc_inc + imm8_sext : pc_inc;
            wisc_pkg::BR_NEZ: pc_next = !rs_zero ? pc_inc + imm8_sext : pc_inc;
            wisc_pkg::BR_LTZ: pc_next = rs_neg ? pc_inc + imm8_sext : pc_inc;
            wisc_pkg::BR_GEZ: pc_next = !rs_neg ? pc_inc + imm8_sext : pc_inc;
            wisc_pkg::BR_J:   pc_next = pc_inc + disp_sext;
            wisc_pkg::BR_JR:  pc_next = rs_data + imm8_sext;
            default:          pc_next = pc_inc;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc     <= '0;
            halt_q <= 1'b0;
        end else begin
            if (dump) halt_q <= 1'b1;
            if (!halt) pc <= pc_next;  // Hold at HALT address
        end
    end

    // JR and JALR targets come from register data, so alignment is a program property
    assert property (@(posedge clk) disable iff (!rst_n) pc[0] == 1'b0)
        else $error("pc_unit: misaligned pc %h", pc);

endmodule

/* verilog/wisc_core.sv */
module wisc_core (
    input  logic                        clk,
    input  logic                        rst_n,
    output logic [wisc_pkg::DATA_W-1:0] imem_addr,
    input  logic [wisc_pkg::DATA_W-1:0] instr,
    output logic [wisc_pkg::DATA_W-1:0] mem_addr,
    output logic [wisc_pkg::DATA_W-1:0] mem_wdata,
    output logic                        mem_write,
    output logic                        mem_read,
    input  logic [wisc_pkg::DATA_W-1:0] mem_rdata,
    output logic                        halt
);

    wisc_pkg::alu_src_e             alu_src;
    wisc_pkg::reg_dst_e             reg_dst;
    wisc_pkg::alu_op_e              alu_op;
    wisc_pkg::br_cond_e             br_cond;
    logic                           reg_write;
    logic                           mem_to_reg;
    logic                           invA;
    logic                           invB;
    logic                           Cin;
    logic                           dump;
    logic [wisc_pkg::DATA_W-1:0]    rs_data;
    logic [wisc_pkg::DATA_W-1:0]    rt_data;
    logic [wisc_pkg::DATA_W-1:0]    op_b;
    logic [wisc_pkg::DATA_W-1:0]    alu_result;
    logic [wisc_pkg::DATA_W-1:0]    pc;
    logic [wisc_pkg::DATA_W-1:0]    pc_inc;
    logic [wisc_pkg::DATA_W-1:0]    wb_data;
    logic [wisc_pkg::REG_IDX_W-1:0] wr_idx;

    master_ctrl master_ctrl_i (
        .opcode(wisc_pkg::opcode_e'(instr[15:11])), .lower_two(instr[1:0]),
        .alu_src(alu_src), .mem_write(mem_write), .mem_read(mem_read),
        .reg_write(reg_write), .mem_to_reg(mem_to_reg), .reg_dst(reg_dst),
        .invA(invA), .invB(invB), .Cin(Cin), .alu_op(alu_op),
        .br_cond(br_cond), .dump(dump)
    );

    reg_file reg_file_i (
        .clk(clk), .rst_n(rst_n),
        .rd_a_idx(instr[10:8]), .rd_b_idx(instr[7:5]),
        .rd_a(rs_data), .rd_b(rt_data),
        .wr_en(reg_write), .wr_idx(wr_idx), .wr_data(wb_data)
    );

    operand_sel operand_sel_i (
        .instr(instr), .alu_src(alu_src), .reg_dst(reg_dst),
        .rt_data(rt_data), .op_b(op_b), .wr_idx(wr_idx)
    );

    alu alu_i (
        .a(rs_data), .b(op_b), .invA(invA), .invB(invB), .Cin(Cin),
        .alu_op(alu_op), .result(alu_result)
    );

    pc_unit pc_unit_i (
        .clk(clk), .rst_n(rst_n), .instr(instr), .br_cond(br_cond),
        .rs_data(rs_data), .dump(dump), .pc(pc), .pc_inc(pc_inc), .halt(halt)
    );

    always_comb begin
        if (mem_to_reg) begin
            wb_data = mem_rdata;
        end else if (reg_dst == wisc_pkg::DST_R7) begin
            wb_data = pc_inc;  // Link value
        end else begin
            wb_data = alu_result;
        end
    end

    assign imem_addr = pc;
    assign mem_addr  = alu_result;
    assign mem_wdata = rt_data;  // ST and STU store bits 7:5

endmodule

/* test/isa_model.sv */
module isa_model;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_STEPS = 4096;

    logic [15:0] trace_pc [MAX_STEPS];  // Expected pc per cycle
    logic        trace_we [MAX_STEPS];  // Expected mem_write per cycle
    logic        trace_re [MAX_STEPS];  // Expected mem_read per cycle
    logic [15:0] st_addr [MAX_STEPS];
    logic [15:0] st_data [MAX_STEPS];
    int          st_cnt;
    int          instr_count;
    logic [15:0] final_pc;

    function automatic logic [15:0] rotl(input logic [15:0] x, input int s);
        return (x << s) | (x >> (16 - s));
    endfunction

    function automatic logic [15:0] rotr(input logic [15:0] x, input int s);
        return (x >> s) | (x << (16 - s));
    endfunction

    function automatic logic [15:0] bit_reverse(input logic [15:0] x);
        logic [15:0] r;
        for (int i = 0; i < 16; i++) begin
            r[i] = x[15-i];
        end
        return r;
    endfunction

    task automatic execute(input logic [15:0] prog [2048], input logic [15:0] dmem_init [128]);
        logic [15:0] regs [8];
        logic [15:0] dmem [128];
        logic [15:0] pc;
        logic [15:0] ins;
        logic [15:0] rs;
        logic [15:0] rt;
        logic [15:0] addr;
        logic [15:0] nxt;
        logic [15:0] s5;
        logic [15:0] z5;
        logic [15:0] s8;
        logic [16:0] wide;
        logic        halted;
        pc = '0;
        for (int i = 0; i < 8; i++) begin
            regs[i] = '0;
        end
        dmem = dmem_init;
        st_cnt = 0;
        instr_count = 0;
        halted = 1'b0;
        while (!halted && instr_count < MAX_STEPS) begin
            ins  = prog[pc[11:1]];
            rs   = regs[ins[10:8]];
            rt   = regs[ins[7:5]];
            s5   = {{11{ins[4]}}, ins[4:0]};
            z5   = {11'd0, ins[4:0]};
            s8   = {{8{ins[7]}}, ins[7:0]};
            addr = rs + s5;
            nxt  = pc + 16'd2;
            trace_pc[instr_count] = pc;
            trace_we[instr_count] = 1'b0;
            trace_re[instr_count] = 1'b0;
            case (wisc_pkg::opcode_e'(ins[15:11]))
                wisc_pkg::OP_HALT: begin
                    halted = 1'b1;
                    nxt = pc;
                end
                wisc_pkg::OP_ADDI:  regs[ins[7:5]] = rs + s5;
                wisc_pkg::OP_SUBI:  regs[ins[7:5]] = s5 - rs;
                wisc_pkg::OP_XORI:  regs[ins[7:5]] = rs ^ z5;
                wisc_pkg::OP_ANDNI: regs[ins[7:5]] = rs & ~z5;
                wisc_pkg::OP_ROLI:  regs[ins[7:5]] = rotl(rs, int'(ins[3:0]));
                wisc_pkg::OP_SLLI:  regs[ins[7:5]] = rs << ins[3:0];
                wisc_pkg::OP_RORI:  regs[ins[7:5]] = rotr(rs, int'(ins[3:0]));
                wisc_pkg::OP_SRLI:  regs[ins[7:5]] = rs >> ins[3:0];
                wisc_pkg::OP_ST, wisc_pkg::OP_STU: begin
                    trace_we[instr_count] = 1'b1;
                    st_addr[st_cnt] = addr;
                    st_data[st_cnt] = rt;
                    st_cnt++;
                    dmem[addr[7:1]] = rt;
                    if (ins[15:11] == wisc_pkg::OP_STU) regs[ins[10:8]] = addr;
                end
                wisc_pkg::OP_LD: begin
                    trace_re[instr_count] = 1'b1;
                    regs[ins[7:5]] = dmem[addr[7:1]];
                end
                wisc_pkg::OP_LBI:   regs[ins[10:8]] = s8;
                wisc_pkg::OP_SLBI:  regs[ins[10:8]] = (rs << 8) | {8'd0, ins[7:0]};
                wisc_pkg::OP_BTR:   regs[ins[4:2]] = bit_reverse(rs);
                wisc_pkg::OP_SHIFT: begin
                    case (ins[1:0])
                        2'b00:   regs[ins[4:2]] = rotl(rs, int'(rt[3:0]));
                        2'b01:   regs[ins[4:2]] = rs << rt[3:0];
                        2'b10:   regs[ins[4:2]] = rotr(rs, int'(rt[3:0]));
                        default: regs[ins[4:2]] = rs >> rt[3:0];
                    endcase
                end
                wisc_pkg::OP_ARITH: begin
                    case (ins[1:0])
                        2'b00:   regs[ins[4:2]] = rs + rt;
                        2'b01:   regs[ins[4:2]] = rt - rs;
                        2'b10:   regs[ins[4:2]] = rs ^ rt;
                        default: regs[ins[4:2]] = rs & ~rt;
                    endcase
                end
                wisc_pkg::OP_SEQ: regs[ins[4:2]] = {15'd0, rs == rt};
                wisc_pkg::OP_SLT: regs[ins[4:2]] = {15'd0, $signed(rs) < $signed(rt)};
                wisc_pkg::OP_SLE: regs[ins[4:2]] = {15'd0, $signed(rs) <= $signed(rt)};
                wisc_pkg::OP_SCO: begin
                    wide = {1'b0, rs} + {1'b0, rt};
                    regs[ins[4:2]] = {15'd0, wide[16]};
                end
                wisc_pkg::OP_BEQZ: if (rs == 16'd0) nxt = pc + 16'd2 + s8;
                wisc_pkg::OP_BNEZ: if (rs != 16'd0) nxt = pc + 16'd2 + s8;
                wisc_pkg::OP_BLTZ: if (rs[15]) nxt = pc + 16'd2 + s8;
                wisc_pkg::OP_BGEZ: if (!rs[15]) nxt = pc + 16'd2 + s8;
                wisc_pkg::OP_J, wisc_pkg::OP_JAL: begin
                    nxt = pc + 16'd2 + {{5{ins[10]}}, ins[10:0]};
                    if (ins[12]) regs[7] = pc + 16'd2;  // JAL links
                end
                wisc_pkg::OP_JR, wisc_pkg::OP_JALR: begin
                    nxt = rs + s8;
                    if (ins[12]) regs[7] = pc + 16'd2;
                end
                default: ;
            endcase
            instr_count++;
            pc = nxt;
        end
        final_pc = pc;
    endtask

endmodule

/* test/wisc_core_tb.sv */
module wisc_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        rst_n;
    logic [15:0] imem_addr;
    logic [15:0] instr;
    logic [15:0] mem_addr;
    logic [15:0] mem_wdata;
    logic        mem_write;
    logic        mem_read;
    logic [15:0] mem_rdata;
    logic        halt;

    logic [15:0] imem [2048];
    logic [15:0] dmem [128];
    int          plen;
    int          cyc;
    int          st_idx;
    int          err_pc;
    int          err_mem;
    int          err_halt;
    int          err_reset;
    logic [15:0] exp_pc;
    logic        exp_we;
    logic        exp_re;
    logic [15:0] exp_addr;
    logic [15:0] exp_wdata;

    wisc_core wisc_core_i (
        .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .instr(instr),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_write(mem_write),
        .mem_read(mem_read), .mem_rdata(mem_rdata), .halt(halt)
    );

    isa_model isa_model_i ();

    assign instr     = imem[imem_addr[11:1]];
    assign mem_rdata = dmem[mem_addr[7:1]];
    assign exp_pc    = isa_model_i.trace_pc[cyc];
    assign exp_we    = isa_model_i.trace_we[cyc];
    assign exp_re    = isa_model_i.trace_re[cyc];
    assign exp_addr  = isa_model_i.st_addr[st_idx];
    assign exp_wdata = isa_model_i.st_data[st_idx];

    always @(posedge clk) begin
        if (rst_n && mem_write) dmem[mem_addr[7:1]] <= mem_wdata;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cyc    <= 0;
            st_idx <= 0;
        end else begin
            if (!halt) cyc <= cyc + 1;
            if (mem_write) st_idx <= st_idx + 1;
        end
    end

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic emit_word(input logic [15:0] w);
        imem[plen] = w;
        plen++;
    endtask

    task automatic emit_store(input logic [2:0] rt);
        emit_word({wisc_pkg::OP_ST, 3'($urandom % 8), rt, 5'($urandom % 32)});
    endtask

    task automatic emit_filler(input int k);
        for (int i = 0; i < k; i++) begin
            emit_word({wisc_pkg::OP_ADDI, 3'($urandom % 8), 3'($urandom % 8), 5'($urandom)});
        end
    endtask

    task automatic emit_random_instr();
        logic [2:0]  rd;
        logic [4:0]  op;
        logic [15:0] target;
        int          k;
        rd = 3'($urandom % 8);
        k  = $urandom % 4;
        case ($urandom % 11)
            0: begin
                op = 5'(8 + $urandom % 4);  // ADDI, SUBI, XORI, ANDNI
                if ($urandom % 2 == 1) op = 5'(20 + $urandom % 4);  // Immediate shifts
                emit_word({op, 3'($urandom % 8), rd, 5'($urandom)});
                emit_store(rd);
            end
            1: begin
                op = ($urandom % 2 == 1) ? wisc_pkg::OP_LBI : wisc_pkg::OP_SLBI;
                emit_word({op, rd, 8'($urandom)});
                emit_store(rd);
            end
            2, 3: begin
                op = 5'(25 + $urandom % 7);  // BTR through SCO
                emit_word({op, 3'($urandom % 8), 3'($urandom % 8), rd, 2'($urandom)});
                emit_store(rd);
            end
            4: begin
                emit_word({wisc_pkg::OP_LD, 3'($urandom % 8), rd, 5'($urandom)});
                emit_store(rd);
            end
            5: emit_store(rd);
            6: begin
                emit_word({wisc_pkg::OP_STU, rd, 3'($urandom % 8), 5'($urandom)});
                emit_store(rd);
            end
            7: begin
                op = 5'(12 + $urandom % 4);  // Zero-compare branches
                emit_word({op, 3'($urandom % 8), 8'(2 * k)});
                emit_filler(k);
            end
            8: begin
                op = ($urandom % 2 == 1) ? wisc_pkg::OP_JAL : wisc_pkg::OP_J;
                emit_word({op, 11'(2 * k)});
                emit_filler(k);
                emit_store(3'd7);
            end
            9: begin
                op = ($urandom % 2 == 1) ? wisc_pkg::OP_JALR : wisc_pkg::OP_JR;
                target = 16'((plen + 3) * 2 + 2 * k);
                emit_word({wisc_pkg::OP_LBI, 3'd6, target[15:8]});
                emit_word({wisc_pkg::OP_SLBI, 3'd6, target[7:0]});
                emit_word({op, 3'd6, 8'd0});
                emit_filler(k);
                emit_store(3'd7);
            end
            default: emit_word({wisc_pkg::OP_NOP, 11'd0});
        endcase
    endtask

    initial begin
        rst_n = 1'b0;
        plen  = 0;
        err_pc = 0;
        err_mem = 0;
        err_halt = 0;
        err_reset = 0;
        void'($urandom(32'h452b3c2d));
        for (int i = 0; i < 2048; i++) begin
            imem[i] = 16'h0000;  // HALT beyond the program
        end
        for (int i = 0; i < 128; i++) begin
            dmem[i] = 16'(i * 16'h9e37) ^ 16'h5a3c;
        end
        for (int r = 0; r < 8; r++) begin
            emit_word({wisc_pkg::OP_LBI, 3'(r), 8'($urandom)});
            emit_word({wisc_pkg::OP_SLBI, 3'(r), 8'($urandom)});
        end
        for (int n = 0; n < 200; n++) begin
            emit_random_instr();
        end
        emit_word({wisc_pkg::OP_HALT, 11'd0});
        isa_model_i.execute(imem, dmem);
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        while (!halt) @(negedge clk);
        repeat (3) @(negedge clk);
        assert (imem_addr == isa_model_i.final_pc)
            else begin
                err_halt++;
                $display("FAIL imem_addr after halt got %h exp %h", imem_addr,
                         isa_model_i.final_pc);
            end
        assert (st_idx == isa_model_i.st_cnt)
            else begin
                err_mem++;
                $display("FAIL st_idx got %h exp %h", st_idx, isa_model_i.st_cnt);
            end
        $display("Errors: pc %0d, memory %0d, halt %0d, reset %0d",
                 err_pc, err_mem, err_halt, err_reset);
        if (err_pc + err_mem + err_halt + err_reset == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        wait (rst_n === 1'b1);
        #((plen + 20) * 40);
        $display("Timeout, the core did not reach halt in time");
        $display("Test FAILED");
        $finish;
    end

    assert property (@(posedge clk) !rst_n |-> (imem_addr == 16'h0 && !mem_write && !halt))
        else begin
            err_reset++;
            $display("FAIL reset imem_addr %h mem_write %h halt %h", imem_addr, mem_write, halt);
        end

    assert property (@(posedge clk) disable iff (!rst_n) imem_addr == exp_pc)
        else begin
            err_pc++;
            $display("FAIL imem_addr got %h exp %h", imem_addr, exp_pc);
        end

    assert property (@(posedge clk) disable iff (!rst_n) mem_write == exp_we)
        else begin
            err_mem++;
            $display("FAIL mem_write got %h exp %h", mem_write, exp_we);
        end

    assert property (@(posedge clk) disable iff (!rst_n) mem_read == exp_re)
        else begin
            err_mem++;
            $display("FAIL mem_read got %h exp %h", mem_read, exp_re);
        end

    assert property (@(posedge clk) disable iff (!rst_n) mem_write |-> mem_addr == exp_addr)
        else begin
            err_mem++;
            $display("FAIL mem_addr got %h exp %h", mem_addr, exp_addr);
        end

    assert property (@(posedge clk) disable iff (!rst_n) mem_write |-> mem_wdata == exp_wdata)
        else begin
            err_mem++;
            $display("FAIL mem_wdata got %h exp %h", mem_wdata, exp_wdata);
        end

    // Halt must rise exactly on the last counted instruction
    assert property (@(posedge clk) disable iff (!rst_n)
        halt == (cyc == isa_model_i.instr_count - 1))
        else begin
            err_halt++;
            $display("FAIL halt got %h exp %h at cycle %h", halt,
                     cyc == isa_model_i.instr_count - 1, cyc);
        end

endmodule

/* tb.f */
verilog/wisc_pkg.sv
verilog/master_ctrl.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/operand_sel.sv
verilog/pc_unit.sv
verilog/wisc_core.sv
test/isa_model.sv
test/wisc_core_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the wisc_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module wisc_core_tb -f tb.f -o wisc_core_tb \
    && ./obj_dir/wisc_core_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0
